/* logic/commit_resp.sv */
/* Commit FSM for ops that answer the core
   Holds off new requests until the address ack or the scalar result shows up */
`timescale 1ns/1ns
`default_nettype none

module commit_resp
  import vseq_cfg_pkg::*;
  import vseq_isa_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_wait_i,
  input  vseq_op_e pe_req_op_i,
  input  logic     addrgen_ack_i,
  input  xdata_t   scalar_resp_i,
  input  logic     scalar_resp_valid_i,
  output logic     scalar_resp_ready_o,
  output logic     resp_valid_o,
  output xdata_t   resp_data_o,
  output logic     hold_o
);

  typedef enum logic {
    st_idle,
    st_wait
  } state_e;

  state_e state_q, state_d;
  // Memory ops finish on the address ack, scalar moves on the result
  logic   is_mem;
  logic   done_evt;

  assign is_mem   = op_unit(pe_req_op_i) inside {vfu_load, vfu_store};
  assign done_evt = is_mem ? addrgen_ack_i : scalar_resp_valid_i;
  assign hold_o   = (state_q == st_wait);

  always_comb begin : p_fsm
    state_d             = state_q;
    resp_valid_o        = 1'b0;
    resp_data_o         = '0;
    scalar_resp_ready_o = 1'b0;
    case (state_q)
      st_idle: begin
        if (in_wait_i) begin
          state_d = st_wait;
        end
      end
      st_wait: begin
        if (done_evt) begin
          state_d      = st_idle;
          resp_valid_o = 1'b1;
          // Scalar result goes back to the core, loads and stores return zero
          if (!is_mem) begin
            resp_data_o         = scalar_resp_i;
            scalar_resp_ready_o = 1'b1;
          end
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  a_resp_in_wait: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> state_q == st_wait
  );

  // Scoreboard must not take a new waiting op while one is open
  a_no_accept_in_wait: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q == st_wait |-> !in_wait_i
  );

endmodule

`default_nettype wire

/* logic/hazard_scoreboard.sv */
/* Execute stage of the sequencer
   Hands out IDs, tracks register readers and writers and issues the PE request */
`timescale 1ns/1ns
`default_nettype none

module hazard_scoreboard
  import vseq_cfg_pkg::*;
  import vseq_isa_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          req_valid_i,
  output logic          req_ready_o,
  input  vseq_op_e      req_op_i,
  input  vreg_t         req_vs1_i,
  input  vreg_t         req_vs2_i,
  input  vreg_t         req_vd_i,
  input  logic          req_use_vs1_i,
  input  logic          req_use_vs2_i,
  input  logic          req_use_vd_i,
  issue_if.exe          issue,
  input  logic          hold_i,
  output logic          in_wait_o,
  input  logic          pe_req_ready_i,
  output logic          pe_req_valid_o,
  output vid_t          pe_req_id_o,
  output vseq_op_e      pe_req_op_o,
  output vfu_e          pe_req_unit_o,
  output vinsn_vec_t    pe_hazard_vs1_o,
  output vinsn_vec_t    pe_hazard_vs2_o,
  output vinsn_vec_t    pe_hazard_vd_o,
  input  unit_vinsn_t   pe_done_i,
  output hazard_table_t hazard_table_o,
  output logic          idle_o
);

  // Last instruction that touched a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_entry_t;

  vreg_entry_t [nr_vregs-1:0] read_list_q, read_list_d;
  vreg_entry_t [nr_vregs-1:0] write_list_q, write_list_d;

  unit_vinsn_t   unit_run_q, unit_run_d;
  hazard_table_t hazard_table_d;
  // Running set as registered, and with this cycle's completions removed
  vinsn_vec_t    running;
  vinsn_vec_t    running_live;
  vid_t          free_id;
  logic          free_found;
  logic          pe_block;
  logic          accept;
  vinsn_vec_t    haz_vs1, haz_vs2, haz_vd;

  //////////////////////////////
  // Running set and free ID
  //////////////////////////////

  always_comb begin : p_running
    running      = '0;
    running_live = '0;
    for (int u = 0; u < nr_vfus; u++) begin
      running      |= unit_run_q[u];
      running_live |= unit_run_q[u] & ~pe_done_i[u];
    end
  end

  // Lowest ID not running anywhere
  always_comb begin : p_free_id
    free_id    = '0;
    free_found = 1'b0;
    for (int i = nr_vinsn - 1; i >= 0; i--) begin
      if (!running[i]) begin
        free_id    = vid_t'(i);
        free_found = 1'b1;
      end
    end
  end

  assign idle_o = ~|running;

  // Previous request still waiting on the PE
  assign pe_block     = pe_req_valid_o && !pe_req_ready_i;
  assign req_ready_o  = !hold_i && !pe_block && free_found && issue.issue_ok;
  assign accept       = req_valid_i && req_ready_o;
  assign issue.accept = accept;
  // Loads, stores and scalar moves hand over to the commit FSM
  assign in_wait_o    = accept && op_waits(req_op_i);

  //////////////////////////////
  // Register access lists
  //////////////////////////////

  always_comb begin : p_lists
    read_list_d  = read_list_q;
    write_list_d = write_list_q;
    // Forget accesses of finished instructions
    for (int v = 0; v < nr_vregs; v++) begin
      read_list_d[v].valid  &= running_live[read_list_q[v].vid];
      write_list_d[v].valid &= running_live[write_list_q[v].vid];
    end

    haz_vs1 = '0;
    haz_vs2 = '0;
    haz_vd  = '0;
    // RAW on both sources
    if (req_use_vs1_i) begin
      haz_vs1[write_list_d[req_vs1_i].vid] = write_list_d[req_vs1_i].valid;
    end
    if (req_use_vs2_i) begin
      haz_vs2[write_list_d[req_vs2_i].vid] = write_list_d[req_vs2_i].valid;
    end
    // WAW and WAR both land on vd
    if (req_use_vd_i) begin
      haz_vd[write_list_d[req_vd_i].vid] = write_list_d[req_vd_i].valid;
      haz_vd[read_list_d[req_vd_i].vid] |= read_list_d[req_vd_i].valid;
    end

    // New instruction becomes the latest user
    if (accept) begin
      if (req_use_vd_i) begin
        write_list_d[req_vd_i] = '{vid: free_id, valid: 1'b1};
      end
      if (req_use_vs1_i) begin
        read_list_d[req_vs1_i] = '{vid: free_id, valid: 1'b1};
      end
      if (req_use_vs2_i) begin
        read_list_d[req_vs2_i] = '{vid: free_id, valid: 1'b1};
      end
    end
  end

  always_comb begin : p_run_next
    for (int u = 0; u < nr_vfus; u++) begin
      unit_run_d[u] = unit_run_q[u] & ~pe_done_i[u];
    end
    if (accept) begin
      unit_run_d[issue.unit][free_id] = 1'b1;
    end
  end

  // Global table, rows cleared of finished producers
  always_comb begin : p_table
    hazard_table_d = hazard_table_o;
    if (accept) begin
      hazard_table_d[free_id] = haz_vs1 | haz_vs2 | haz_vd;
    end
    for (int id = 0; id < nr_vinsn; id++) begin
      hazard_table_d[id] &= running_live;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      unit_run_q     <= '0;
      read_list_q    <= '0;
      write_list_q   <= '0;
      hazard_table_o <= '0;
      pe_req_valid_o <= 1'b0;
    end else begin
      unit_run_q     <= unit_run_d;
      read_list_q    <= read_list_d;
      write_list_q   <= write_list_d;
      hazard_table_o <= hazard_table_d;
      if (accept) begin
        pe_req_valid_o <= 1'b1;
      end else if (pe_req_ready_i) begin
        pe_req_valid_o <= 1'b0;
      end
    end
  end

  // Request payload, loaded only on accept
  always_ff @(posedge clk_i) begin : p_req
    if (accept) begin
      pe_req_id_o     <= free_id;
      pe_req_op_o     <= req_op_i;
      pe_req_unit_o   <= issue.unit;
      pe_hazard_vs1_o <= haz_vs1;
      pe_hazard_vs2_o <= haz_vs2;
      pe_hazard_vd_o  <= haz_vd;
    end
  end

  // A stalled request stays put until the PE takes it
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_o && !pe_req_ready_i |=>
      pe_req_valid_o && $stable(pe_req_id_o) && $stable(pe_req_op_o)
  );

endmodule

`default_nettype wire

/* logic/insn_decode.sv */
/* Decode stage of the sequencer
   Maps the op to its unit and tracks how full each unit queue is */
`timescale 1ns/1ns
`default_nettype none

module insn_decode
  import vseq_cfg_pkg::*;
  import vseq_isa_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  vseq_op_e    req_op_i,
  issue_if.dec        issue,
  input  unit_vinsn_t pe_done_i
);

  // Instructions sitting in each unit queue
  unit_qcnt_t cnt_q;
  // Per-unit increment and decrement requests
  vfu_vec_t   cnt_up;
  vfu_vec_t   cnt_down;

  assign issue.unit = op_unit(req_op_i);

  // Room left in the target queue
  assign issue.issue_ok = (cnt_q[issue.unit] < queue_depth[issue.unit]);

  for (genvar u = 0; u < nr_vfus; u++) begin : gen_cnt_ctrl
    // Count up only on the unit that takes the request
    assign cnt_up[u]   = issue.accept && (issue.unit == vfu_e'(u));
    // Any completion of that unit frees one slot
    assign cnt_down[u] = |pe_done_i[u];

    // Gating by issue_ok in the scoreboard keeps every queue in range
    a_cnt_bound: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      cnt_q[u] <= queue_depth[u]
    );
  end

  //////////////////////////////
  // Queue occupancy counters
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int u = 0; u < nr_vfus; u++) begin
        // Accept and done together cancel out
        if (cnt_up[u] && !cnt_down[u]) begin
          cnt_q[u] <= cnt_q[u] + qcnt_t'(1);
        end else if (cnt_down[u] && !cnt_up[u]) begin
          cnt_q[u] <= cnt_q[u] - qcnt_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/issue_if.sv */
/* Issue link between decode and the scoreboard
   Decode offers the target unit and queue room, the scoreboard pulses accept */
`timescale 1ns/1ns
`default_nettype none

interface issue_if
  import vseq_isa_pkg::*;
();
  // Unit that runs the current request
  vfu_e unit;
  // Target queue has room
  logic issue_ok;
  // Request taken on this clock
  logic accept;

  modport dec (
    output unit,
    output issue_ok,
    input  accept
  );

  modport exe (
    input  unit,
    input  issue_ok,
    output accept
  );
endinterface

`default_nettype wire

/* logic/vseq_cfg_pkg.sv */
/* Sizes, instruction IDs and per-unit queue depths of the vector sequencer
   Imported next to the ISA package by every RTL module */
`default_nettype none

package vseq_cfg_pkg;
  import vseq_isa_pkg::*;

  // Instructions in flight, one ID each
  localparam int unsigned nr_vinsn = 8;
  // Architectural vector registers
  localparam int unsigned nr_vregs = 32;
  // Scalar data returned to the core
  localparam int unsigned xlen = 32;

  typedef logic [$clog2(nr_vinsn)-1:0] vid_t;
  typedef logic [$clog2(nr_vregs)-1:0] vreg_t;
  typedef logic [nr_vinsn-1:0]         vinsn_vec_t;
  typedef logic [2:0]                  qcnt_t;
  typedef logic [xlen-1:0]             xdata_t;

  // Queue depth per unit, same order as vfu_e
  localparam qcnt_t queue_depth [nr_vfus] = '{3'd4, 3'd2, 3'd2, 3'd2, 3'd1};

  // One instruction vector per unit
  typedef vinsn_vec_t [nr_vfus-1:0] unit_vinsn_t;
  // One occupancy count per unit
  typedef qcnt_t [nr_vfus-1:0] unit_qcnt_t;
  // Row N lists the instructions that instruction N waits on
  typedef vinsn_vec_t [nr_vinsn-1:0] hazard_table_t;
endpackage

`default_nettype wire

/* logic/vseq_isa_pkg.sv */
/* Vector operations, execution units and the helpers that classify them
   Ops are grouped in ranges so that one range maps to one unit */
`default_nettype none

package vseq_isa_pkg;
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_mul,
    op_slideup,
    op_slidedown,
    op_load,
    op_store,
    op_mv_xs
  } vseq_op_e;

  // ALU and multiplier share the arith queue
  typedef enum logic [2:0] {
    vfu_arith,
    vfu_slide,
    vfu_load,
    vfu_store,
    vfu_none
  } vfu_e;

  localparam int unsigned nr_vfus = 5;

  typedef logic [nr_vfus-1:0] vfu_vec_t;

  // Unit that executes an operation
  function automatic vfu_e op_unit(vseq_op_e op);
    vfu_e unit;
    case (op) inside
      [op_add:op_mul]:           unit = vfu_arith;
      [op_slideup:op_slidedown]: unit = vfu_slide;
      op_load:                   unit = vfu_load;
      op_store:                  unit = vfu_store;
      default:                   unit = vfu_none;
    endcase
    return unit;
  endfunction

  // Ops that report back to the core before the next one enters
  function automatic logic op_waits(vseq_op_e op);
    return op inside {op_load, op_store, op_mv_xs};
  endfunction
endpackage

`default_nettype wire

/* logic/vseq_top.sv */
/* Vector instruction sequencer top level
   Decode, scoreboard and commit stages behind plain ports */
`timescale 1ns/1ns
`default_nettype none

module vseq_top
  import vseq_cfg_pkg::*;
  import vseq_isa_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  // Core request
  input  logic          req_valid_i,
  output logic          req_ready_o,
  input  vseq_op_e      req_op_i,
  input  vreg_t         req_vs1_i,
  input  vreg_t         req_vs2_i,
  input  vreg_t         req_vd_i,
  input  logic          req_use_vs1_i,
  input  logic          req_use_vs2_i,
  input  logic          req_use_vd_i,
  // Core response
  output logic          resp_valid_o,
  output xdata_t        resp_data_o,
  output logic          idle_o,
  // PE request and completions
  output logic          pe_req_valid_o,
  input  logic          pe_req_ready_i,
  output vid_t          pe_req_id_o,
  output vseq_op_e      pe_req_op_o,
  output vfu_e          pe_req_unit_o,
  output vinsn_vec_t    pe_hazard_vs1_o,
  output vinsn_vec_t    pe_hazard_vs2_o,
  output vinsn_vec_t    pe_hazard_vd_o,
  input  unit_vinsn_t   pe_done_i,
  output hazard_table_t hazard_table_o,
  // Address generation and scalar result
  input  logic          addrgen_ack_i,
  input  xdata_t        scalar_resp_i,
  input  logic          scalar_resp_valid_i,
  output logic          scalar_resp_ready_o
);

  logic hold;
  logic in_wait;

  issue_if issue ();

  insn_decode u_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_op_i  (req_op_i),
    .issue     (issue.dec),
    .pe_done_i (pe_done_i)
  );

  hazard_scoreboard u_scoreboard (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_vs1_i       (req_vs1_i),
    .req_vs2_i       (req_vs2_i),
    .req_vd_i        (req_vd_i),
    .req_use_vs1_i   (req_use_vs1_i),
    .req_use_vs2_i   (req_use_vs2_i),
    .req_use_vd_i    (req_use_vd_i),
    .issue           (issue.exe),
    .hold_i          (hold),
    .in_wait_o       (in_wait),
    .pe_req_ready_i  (pe_req_ready_i),
    .pe_req_valid_o  (pe_req_valid_o),
    .pe_req_id_o     (pe_req_id_o),
    .pe_req_op_o     (pe_req_op_o),
    .pe_req_unit_o   (pe_req_unit_o),
    .pe_hazard_vs1_o (pe_hazard_vs1_o),
    .pe_hazard_vs2_o (pe_hazard_vs2_o),
    .pe_hazard_vd_o  (pe_hazard_vd_o),
    .pe_done_i       (pe_done_i),
    .hazard_table_o  (hazard_table_o),
    .idle_o          (idle_o)
  );

  commit_resp u_commit (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .in_wait_i           (in_wait),
    .pe_req_op_i         (pe_req_op_o),
    .addrgen_ack_i       (addrgen_ack_i),
    .scalar_resp_i       (scalar_resp_i),
    .scalar_resp_valid_i (scalar_resp_valid_i),
    .scalar_resp_ready_o (scalar_resp_ready_o),
    .resp_valid_o        (resp_valid_o),
    .resp_data_o         (resp_data_o),
    .hold_o              (hold)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the sequencer testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module vseq_tb \
  -f verilog.f -o vseq_sim || exit 1
./obj_dir/vseq_sim > sim.log 2>&1 ; cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

/* verif/vseq_golden.txt */
// test flags done_unit done_mask op vs1 vs2 vd use kind scalar_data exp_id exp_vs1 exp_vs2 exp_vd
// flags 1 request 2 done after stall, use 1 vs1 2 vs2 4 vd, kind 1 addrgen ack 2 scalar result
1 1 0 00 0 02 03 01 7 0 00000000 0 00 00 00
2 1 0 00 1 01 05 04 7 0 00000000 1 01 00 00
2 1 0 00 2 04 06 02 7 0 00000000 2 02 00 01
2 1 0 00 3 00 02 05 6 0 00000000 3 00 04 02
1 1 0 01 0 08 09 07 7 0 00000000 0 00 00 00
3 1 0 00 0 0b 0c 0a 7 0 00000000 4 00 00 00
3 3 0 02 0 0a 0e 0d 7 0 00000000 1 10 00 00
4 1 0 00 4 00 05 10 6 0 00000000 5 00 08 00
4 1 1 08 3 00 10 11 6 0 00000000 3 00 20 00
5 1 0 01 5 00 00 14 4 1 00000000 0 00 00 00
5 1 0 00 6 14 00 00 1 1 00000000 6 01 00 00
6 1 0 00 7 00 0d 00 2 2 5a3c9e17 7 00 02 00
1 0 0 02 0 00 00 00 0 0 00000000 0 00 00 00
1 0 0 04 0 00 00 00 0 0 00000000 0 00 00 00
1 0 0 10 0 00 00 00 0 0 00000000 0 00 00 00
1 0 1 08 0 00 00 00 0 0 00000000 0 00 00 00
1 0 1 20 0 00 00 00 0 0 00000000 0 00 00 00
1 0 2 01 0 00 00 00 0 0 00000000 0 00 00 00
1 0 3 40 0 00 00 00 0 0 00000000 0 00 00 00
1 0 4 80 0 00 00 00 0 0 00000000 0 00 00 00

/* verif/vseq_tb.sv */
/* Self-checking testbench of the vector sequencer
   Replays verif/vseq_golden.txt and checks IDs, hazards, stalls and core responses */
`timescale 1ns/1ns
`default_nettype none

module vseq_tb
  import vseq_cfg_pkg::*;
  import vseq_isa_pkg::*;
();

  // Tokens per golden line, see the file's own column comment
  localparam int nr_fields   = 15;
  localparam int max_lines   = 32;
  // Cycles a stalled or waiting request is watched
  localparam int hold_cycles = 3;
  localparam int max_wait    = 20;
  // Unit each op code runs on, ALU and multiplier share arith
  localparam logic [2:0] unit_of_op [8] = '{3'd0, 3'd0, 3'd0, 3'd1, 3'd1, 3'd2, 3'd3, 3'd4};

  logic          clk_i;
  logic          rst_ni;
  logic          req_valid_i;
  logic          req_ready_o;
  vseq_op_e      req_op_i;
  vreg_t         req_vs1_i;
  vreg_t         req_vs2_i;
  vreg_t         req_vd_i;
  logic          req_use_vs1_i;
  logic          req_use_vs2_i;
  logic          req_use_vd_i;
  logic          resp_valid_o;
  xdata_t        resp_data_o;
  logic          idle_o;
  logic          pe_req_valid_o;
  logic          pe_req_ready_i;
  vid_t          pe_req_id_o;
  vseq_op_e      pe_req_op_o;
  vfu_e          pe_req_unit_o;
  vinsn_vec_t    pe_hazard_vs1_o;
  vinsn_vec_t    pe_hazard_vs2_o;
  vinsn_vec_t    pe_hazard_vd_o;
  unit_vinsn_t   pe_done_i;
  hazard_table_t hazard_table_o;
  logic          addrgen_ack_i;
  xdata_t        scalar_resp_i;
  logic          scalar_resp_valid_i;
  logic          scalar_resp_ready_o;

  logic [31:0] golden [nr_fields * max_lines];
  // Fields of the line being replayed
  logic [31:0] fld [nr_fields];
  // Reference running set and hazard rows
  vinsn_vec_t  run_model;
  vinsn_vec_t  row_model [nr_vinsn];
  int          n_lines = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          steps_ok = 0;
  int          seed = 32'h2136a403;

  vseq_top uut (.*);

  initial begin : p_clk
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Checks and drivers
  //////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      n_errors++;
    end
  endtask

  // One-cycle completion pulse, the model forgets the finished IDs
  task automatic apply_done(input logic [2:0] unit, input vinsn_vec_t mask);
    @(posedge clk_i);
    pe_done_i[unit] <= mask;
    @(posedge clk_i);
    pe_done_i <= '0;
    run_model &= ~mask;
    for (int i = 0; i < nr_vinsn; i++) begin
      row_model[i] &= ~mask;
    end
  endtask

  task automatic wait_accept(output logic ok);
    ok = 1'b0;
    for (int cyc = 0; cyc < max_wait && !ok; cyc++) begin
      @(negedge clk_i);
      ok = req_ready_o;
    end
  endtask

  // Follows the PE request until the edge where the PE takes it
  task automatic check_pe_request();
    logic taken;
    int   rnd;
    taken = 1'b0;
    for (int cyc = 0; cyc < max_wait && !taken; cyc++) begin
      @(negedge clk_i);
      check_value("pe_req_valid_o", 64'(pe_req_valid_o), 64'd1);
      check_value("pe_req_id_o", 64'(pe_req_id_o), 64'(fld[11]));
      check_value("pe_req_op_o", 64'(pe_req_op_o), 64'(fld[4]));
      check_value("pe_req_unit_o", 64'(pe_req_unit_o), 64'(unit_of_op[fld[4][2:0]]));
      check_value("pe_hazard_vs1_o", 64'(pe_hazard_vs1_o), 64'(fld[12]));
      check_value("pe_hazard_vs2_o", 64'(pe_hazard_vs2_o), 64'(fld[13]));
      check_value("pe_hazard_vd_o", 64'(pe_hazard_vd_o), 64'(fld[14]));
      taken = pe_req_ready_i;
      // Held request keeps the core out
      if (!taken) begin
        check_value("req_ready_o", 64'(req_ready_o), 64'd0);
      end
      @(posedge clk_i);
      if (!taken && fld[0] == 4) begin
        rnd = $random(seed);
        pe_req_ready_i <= rnd[0];
      end
    end
    pe_req_ready_i <= 1'b1;
    if (!taken) begin
      $display("PE request of ID %0d was never taken", fld[11]);
      n_errors++;
    end
  endtask

  // Commit FSM waits for the ack or the scalar result, then answers once
  task automatic check_response();
    logic [31:0] exp_data;
    exp_data = (fld[9] == 2) ? fld[10] : 32'd0;
    repeat (hold_cycles) begin
      @(negedge clk_i);
      check_value("req_ready_o", 64'(req_ready_o), 64'd0);
      check_value("resp_valid_o", 64'(resp_valid_o), 64'd0);
    end
    @(posedge clk_i);
    if (fld[9] == 2) begin
      scalar_resp_valid_i <= 1'b1;
      scalar_resp_i       <= fld[10];
    end else begin
      addrgen_ack_i <= 1'b1;
    end
    @(negedge clk_i);
    check_value("resp_valid_o", 64'(resp_valid_o), 64'd1);
    check_value("resp_data_o", 64'(resp_data_o), 64'(exp_data));
    check_value("scalar_resp_ready_o", 64'(scalar_resp_ready_o), 64'(fld[9] == 2));
    @(posedge clk_i);
    addrgen_ack_i       <= 1'b0;
    scalar_resp_valid_i <= 1'b0;
    @(negedge clk_i);
    check_value("resp_valid_o", 64'(resp_valid_o), 64'd0);
  endtask

  task automatic check_state();
    @(negedge clk_i);
    check_value("idle_o", 64'(idle_o), 64'(run_model == '0));
    check_value("pe_req_valid_o", 64'(pe_req_valid_o), 64'd0);
    for (int i = 0; i < nr_vinsn; i++) begin
      check_value($sformatf("hazard_table_o[%0d]", i), 64'(hazard_table_o[i]),
                  64'(row_model[i]));
    end
  endtask

  //////////////////////////////
  // Golden replay
  //////////////////////////////

  initial begin : p_main
    int   errs_before;
    logic ok;
    // Unread words keep an address-derived marker
    for (int k = 0; k < nr_fields * max_lines; k++) begin
      golden[k] = ~k;
    end
    $readmemh("verif/vseq_golden.txt", golden);
    while (n_lines < max_lines && golden[n_lines * nr_fields] != ~(n_lines * nr_fields)) begin
      n_lines++;
    end
    run_model = '0;
    for (int i = 0; i < nr_vinsn; i++) begin
      row_model[i] = '0;
    end

    rst_ni              <= 1'b0;
    req_valid_i         <= 1'b0;
    req_op_i            <= op_add;
    req_vs1_i           <= '0;
    req_vs2_i           <= '0;
    req_vd_i            <= '0;
    req_use_vs1_i       <= 1'b0;
    req_use_vs2_i       <= 1'b0;
    req_use_vd_i        <= 1'b0;
    pe_req_ready_i      <= 1'b1;
    pe_done_i           <= '0;
    addrgen_ack_i       <= 1'b0;
    scalar_resp_i       <= '0;
    scalar_resp_valid_i <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    if (n_lines == 0) begin
      $display("golden file is empty or missing");
      n_errors++;
    end
    for (int l = 0; l < n_lines; l++) begin
      errs_before = n_errors;
      for (int f = 0; f < nr_fields; f++) begin
        fld[f] = golden[l * nr_fields + f];
      end
      if (!fld[1][1] && fld[3] != 0) begin
        apply_done(fld[2][2:0], fld[3][7:0]);
      end
      if (fld[1][0]) begin
        @(posedge clk_i);
        req_valid_i   <= 1'b1;
        req_op_i      <= vseq_op_e'(fld[4][3:0]);
        req_vs1_i     <= fld[5][4:0];
        req_vs2_i     <= fld[6][4:0];
        req_vd_i      <= fld[7][4:0];
        req_use_vs1_i <= fld[8][0];
        req_use_vs2_i <= fld[8][1];
        req_use_vd_i  <= fld[8][2];
        // Full queue, the request must sit until a completion frees a slot
        if (fld[1][1]) begin
          repeat (hold_cycles) begin
            @(negedge clk_i);
            check_value("req_ready_o", 64'(req_ready_o), 64'd0);
          end
          apply_done(fld[2][2:0], fld[3][7:0]);
        end
        wait_accept(ok);
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        if (!ok) begin
          $display("request of line %0d was never accepted", l);
          n_errors++;
        end else begin
          run_model[fld[11][2:0]] = 1'b1;
          row_model[fld[11][2:0]] = fld[12][7:0] | fld[13][7:0] | fld[14][7:0];
          if (fld[0] == 4) begin
            pe_req_ready_i <= 1'b0;
          end
          check_pe_request();
          if (fld[9] != 0) begin
            check_response();
          end
        end
      end
      check_state();
      if (n_errors == errs_before) begin
        steps_ok++;
      end
      $display("step %0d test %0d %s", l, fld[0], (n_errors == errs_before) ? "ok" : "failed");
    end

    $display("steps %0d, passed %0d, checks %0d, errors %0d",
             n_lines, steps_ok, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Budget of 50 cycles per golden line
  initial begin : p_watchdog
    wait (n_lines != 0);
    repeat (50 * n_lines) @(posedge clk_i);
    $display("watchdog expired after %0d cycles", 50 * n_lines);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/vseq_isa_pkg.sv
logic/vseq_cfg_pkg.sv
logic/issue_if.sv
logic/insn_decode.sv
logic/hazard_scoreboard.sv
logic/commit_resp.sv
logic/vseq_top.sv
verif/vseq_tb.sv
